//--- hdl/cache_bus_pkg.sv
package cache_bus_pkg;

   ////////////////////////////////////////
   // Bus geometry
   ////////////////////////////////////////

   // Byte address width on the shared bus
   localparam int unsigned BUS_ADDRESS_WIDTH = 20;
   // Log2 of bytes per line
   localparam int unsigned BUS_DATA_WIDTH_SHIFT = 4;
   // One line in bits
   localparam int unsigned BUS_DATA_WIDTH = (2 ** BUS_DATA_WIDTH_SHIFT) * 8;
   // Line address drops the byte offset
   localparam int unsigned LINE_ADDR_WIDTH = BUS_ADDRESS_WIDTH - BUS_DATA_WIDTH_SHIFT;

   ////////////////////////////////////////
   // Types
   ////////////////////////////////////////

   typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
   typedef logic [BUS_DATA_WIDTH-1:0]  line_data_t;

   // Request toward the bus slave, also the data cache request
   typedef struct packed {
      logic       valid;
      logic       we;
      line_addr_t line_addr;
   } bus_req_t;

   // Instruction fill sequencing
   typedef enum logic {
      IFILL_IDLE,
      IFILL_WAIT_BUS
   } ifill_state_t;

   // Data cache flush sequencing
   typedef enum logic [1:0] {
      DFLUSH_IDLE,
      DFLUSH_SCAN,
      DFLUSH_WRITE,
      DFLUSH_DONE
   } dflush_state_t;

endpackage

//--- hdl/icache_fill_unit.sv
`timescale 1ns/1ps

module icache_fill_unit (
   input  logic                    clk_i,
   input  logic                    rst_i,

   // Miss side
   input  logic                    miss_valid_i,
   input  cache_bus_pkg::line_addr_t miss_addr_i,
   output logic                    fill_done_o,
   output cache_bus_pkg::line_data_t fill_line_o,

   // Toward the arbiter
   output cache_bus_pkg::line_addr_t bus_addr_o,
   output logic                    bus_valid_o,
   output logic                    blocking_n_o,
   output logic                    flushing_n_o,

   // Routed response and read data
   input  logic                    bus_valid_i,
   input  cache_bus_pkg::line_data_t bus_rdata_i
);

   import cache_bus_pkg::*;

   ifill_state_t state_q;
   line_addr_t   addr_q;
   line_data_t   line_q;
   logic         done_q;

   ////////////////////////////////////////
   // Fill FSM
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= IFILL_IDLE;
         done_q  <= 1'b0;
      end else begin
         // Done is a single cycle pulse
         done_q <= 1'b0;
         case (state_q)
            IFILL_IDLE: begin
               // Misses only taken while idle
               if (miss_valid_i) begin
                  state_q <= IFILL_WAIT_BUS;
               end
            end
            IFILL_WAIT_BUS: begin
               // Response drops the request on this edge
               if (bus_valid_i) begin
                  state_q <= IFILL_IDLE;
                  done_q  <= 1'b1;
               end
            end
            default: state_q <= IFILL_IDLE;
         endcase
      end
   end

   // Miss address and returned line
   always_ff @(posedge clk_i) begin
      if (state_q == IFILL_IDLE && miss_valid_i) begin
         addr_q <= miss_addr_i;
      end
      if (state_q == IFILL_WAIT_BUS && bus_valid_i) begin
         line_q <= bus_rdata_i;
      end
   end

   ////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////

   // Request held for the whole wait
   assign bus_valid_o  = (state_q == IFILL_WAIT_BUS);
   assign bus_addr_o   = addr_q;
   // Blocked from miss until line back
   assign blocking_n_o = (state_q == IFILL_IDLE);
   // Busy on the bus while request pending
   assign flushing_n_o = ~bus_valid_o;

   assign fill_done_o  = done_q;
   assign fill_line_o  = line_q;

endmodule

//--- hdl/dcache_line_unit.sv
`timescale 1ns/1ps

module dcache_line_unit #(
   parameter int unsigned DCACHE_LINES = 4
) (
   input  logic                        clk_i,
   input  logic                        rst_i,

   // Store port from outside
   input  logic                        store_valid_i,
   input  logic [$clog2(DCACHE_LINES)-1:0] store_index_i,
   input  cache_bus_pkg::line_addr_t   store_addr_i,
   input  cache_bus_pkg::line_data_t   store_data_i,

   // Flush command
   input  logic                        flush_start_i,
   output logic                        flush_done_o,

   // Toward arbiter and memory
   output cache_bus_pkg::bus_req_t     bus_req_o,
   output cache_bus_pkg::line_data_t   bus_wdata_o,
   output logic                        flushing_n_o,
   input  logic                        bus_valid_i
);

   import cache_bus_pkg::*;

   localparam int unsigned IDX_W = $clog2(DCACHE_LINES);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DCACHE_LINES - 1);

   // Line store, payload only
   line_addr_t addr_mem [DCACHE_LINES];
   line_data_t data_mem [DCACHE_LINES];

   // Per entry status
   logic [DCACHE_LINES-1:0] valid_q;
   logic [DCACHE_LINES-1:0] dirty_q;

   dflush_state_t    state_q;
   logic [IDX_W-1:0] idx_q;
   logic             store_en;

   // Stores blocked during flush
   assign store_en = store_valid_i && (state_q == DFLUSH_IDLE);

   always_ff @(posedge clk_i) begin
      if (store_en) begin
         addr_mem[store_index_i] <= store_addr_i;
         data_mem[store_index_i] <= store_data_i;
      end
   end

   ////////////////////////////////////////
   // Flush sequencer
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= DFLUSH_IDLE;
         idx_q   <= '0;
         valid_q <= '0;
         dirty_q <= '0;
      end else begin
         case (state_q)
            DFLUSH_IDLE: begin
               if (store_en) begin
                  valid_q[store_index_i] <= 1'b1;
                  dirty_q[store_index_i] <= 1'b1;
               end
               if (flush_start_i) begin
                  idx_q   <= '0;
                  state_q <= DFLUSH_SCAN;
               end
            end
            DFLUSH_SCAN: begin
               // One entry checked per cycle
               if (valid_q[idx_q] && dirty_q[idx_q]) begin
                  state_q <= DFLUSH_WRITE;
               end else if (idx_q == LAST_IDX) begin
                  state_q <= DFLUSH_DONE;
               end else begin
                  idx_q <= idx_q + 1'b1;
               end
            end
            DFLUSH_WRITE: begin
               // Line is clean once memory answers
               if (bus_valid_i) begin
                  dirty_q[idx_q] <= 1'b0;
                  if (idx_q == LAST_IDX) begin
                     state_q <= DFLUSH_DONE;
                  end else begin
                     idx_q   <= idx_q + 1'b1;
                     state_q <= DFLUSH_SCAN;
                  end
               end
            end
            DFLUSH_DONE: state_q <= DFLUSH_IDLE;
            default:     state_q <= DFLUSH_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////

   // Writeback request, only ever a write
   assign bus_req_o.valid     = (state_q == DFLUSH_WRITE);
   assign bus_req_o.we        = 1'b1;
   assign bus_req_o.line_addr = addr_mem[idx_q];
   assign bus_wdata_o         = data_mem[idx_q];

   // Low through the whole flush, done cycle included
   assign flushing_n_o = (state_q == DFLUSH_IDLE);
   assign flush_done_o = (state_q == DFLUSH_DONE);

endmodule

//--- hdl/cache_arbiter.sv
`timescale 1ns/1ps

module cache_arbiter (
   input  logic                      clk_i,
   input  logic                      rst_i,

   // Owner status from both sides
   input  logic                      icache_blocking_n_i,
   input  logic                      icache_flushing_n_i,
   input  logic                      dcache_flushing_n_i,

   // Instruction side, read only
   input  cache_bus_pkg::line_addr_t icache_bus_addr_i,
   input  logic                      icache_bus_valid_i,
   output logic                      icache_bus_valid_o,

   // Data side
   input  cache_bus_pkg::bus_req_t   dcache_bus_req_i,
   output logic                      dcache_bus_valid_o,

   // Shared bus
   output cache_bus_pkg::bus_req_t   bus_req_o,
   input  logic                      bus_valid_i
);

   import cache_bus_pkg::*;

   // 0 selects instruction side, 1 data side
   logic     cache_sel_q;
   logic     updating_q;
   logic     cache_sel_next;
   logic     owner_flushing_n;
   bus_req_t sel_req;

   // Data side wins only while flushing and icache not stalled
   assign cache_sel_next = icache_blocking_n_i & ~dcache_flushing_n_i;

   // Current owner between transfers when high
   assign owner_flushing_n = cache_sel_q ? dcache_flushing_n_i : icache_flushing_n_i;

   ////////////////////////////////////////
   // Request mux
   ////////////////////////////////////////

   always_comb begin
      if (cache_sel_q) begin
         sel_req = dcache_bus_req_i;
      end else begin
         sel_req.valid     = icache_bus_valid_i;
         sel_req.we        = 1'b0;
         sel_req.line_addr = icache_bus_addr_i;
      end
      bus_req_o       = sel_req;
      // No new request while handing over
      bus_req_o.valid = sel_req.valid & ~updating_q;
   end

   // Response only to the owner
   assign icache_bus_valid_o = ~cache_sel_q & bus_valid_i;
   assign dcache_bus_valid_o = cache_sel_q & bus_valid_i;

   ////////////////////////////////////////
   // Owner switch
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cache_sel_q <= 1'b0;
         updating_q  <= 1'b0;
      end else if (updating_q) begin
         // Move select once the bus is quiet
         if (!bus_valid_i) begin
            cache_sel_q <= cache_sel_next;
            updating_q  <= 1'b0;
         end
      end else if (owner_flushing_n && (cache_sel_q != cache_sel_next)) begin
         updating_q <= 1'b1;
      end
   end

endmodule

//--- hdl/bus_line_memory.sv
`timescale 1ns/1ps

module bus_line_memory #(
   parameter int unsigned MEM_LATENCY = 4,
   parameter int unsigned MEM_LINES   = 256
) (
   input  logic                      clk_i,
   input  logic                      rst_i,

   // Arbitrated request and write line
   input  cache_bus_pkg::bus_req_t   bus_req_i,
   input  cache_bus_pkg::line_data_t bus_wdata_i,

   // Response pulse and read line
   output logic                      bus_valid_o,
   output cache_bus_pkg::line_data_t bus_rdata_o
);

   import cache_bus_pkg::*;

   localparam int unsigned IDX_W = $clog2(MEM_LINES);
   localparam int unsigned CNT_W = $clog2(MEM_LATENCY + 1);

   // Line array, zero at start
   line_data_t mem_q [MEM_LINES] = '{default: '0};

   logic             busy_q;
   logic [CNT_W-1:0] cnt_q;
   logic             rsp_valid_q;
   logic             we_q;
   logic [IDX_W-1:0] idx_q;
   line_data_t       rdata_q;
   logic             accept;
   logic             finish;

   // Not while the previous response is still out
   assign accept = bus_req_i.valid && !busy_q && !rsp_valid_q;
   // Countdown expired
   assign finish = busy_q && (cnt_q == '0);

   ////////////////////////////////////////
   // Latency counter
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_q      <= 1'b0;
         cnt_q       <= '0;
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= 1'b0;
         if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(MEM_LATENCY - 1);
         end else if (finish) begin
            busy_q      <= 1'b0;
            rsp_valid_q <= 1'b1;
         end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Array access
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      // Request captured at acceptance
      if (accept) begin
         we_q  <= bus_req_i.we;
         idx_q <= bus_req_i.line_addr[IDX_W-1:0];
      end
      // Write data still held by requester here
      if (finish) begin
         if (we_q) begin
            mem_q[idx_q] <= bus_wdata_i;
         end else begin
            rdata_q <= mem_q[idx_q];
         end
      end
   end

   assign bus_valid_o = rsp_valid_q;
   assign bus_rdata_o = rdata_q;

endmodule

//--- hdl/cache_bus_top.sv
`timescale 1ns/1ps

module cache_bus_top #(
   parameter int unsigned MEM_LATENCY  = 4,
   parameter int unsigned MEM_LINES    = 256,
   parameter int unsigned DCACHE_LINES = 4
) (
   input  logic                        clk_i,
   input  logic                        rst_i,

   // Instruction miss and fill
   input  logic                        miss_valid_i,
   input  cache_bus_pkg::line_addr_t   miss_addr_i,
   output logic                        fill_done_o,
   output cache_bus_pkg::line_data_t   fill_line_o,

   // Data stores and flush
   input  logic                        store_valid_i,
   input  logic [$clog2(DCACHE_LINES)-1:0] store_index_i,
   input  cache_bus_pkg::line_addr_t   store_addr_i,
   input  cache_bus_pkg::line_data_t   store_data_i,
   input  logic                        flush_start_i,
   output logic                        flush_done_o
);

   import cache_bus_pkg::*;

   // Instruction side
   line_addr_t icache_bus_addr;
   logic       icache_bus_valid;
   logic       icache_rsp_valid;
   logic       icache_blocking_n;
   logic       icache_flushing_n;

   // Data side
   bus_req_t   dcache_req;
   line_data_t dcache_wdata;
   logic       dcache_flushing_n;
   logic       dcache_rsp_valid;

   // Shared bus
   bus_req_t   bus_req;
   logic       bus_valid;
   line_data_t bus_rdata;

   ////////////////////////////////////////
   // Requesters
   ////////////////////////////////////////

   icache_fill_unit i_icache_fill_unit (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .miss_valid_i (miss_valid_i),
      .miss_addr_i  (miss_addr_i),
      .fill_done_o  (fill_done_o),
      .fill_line_o  (fill_line_o),
      .bus_addr_o   (icache_bus_addr),
      .bus_valid_o  (icache_bus_valid),
      .blocking_n_o (icache_blocking_n),
      .flushing_n_o (icache_flushing_n),
      .bus_valid_i  (icache_rsp_valid),
      // Read data straight from memory
      .bus_rdata_i  (bus_rdata)
   );

   dcache_line_unit #(
      .DCACHE_LINES (DCACHE_LINES)
   ) i_dcache_line_unit (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .store_valid_i (store_valid_i),
      .store_index_i (store_index_i),
      .store_addr_i  (store_addr_i),
      .store_data_i  (store_data_i),
      .flush_start_i (flush_start_i),
      .flush_done_o  (flush_done_o),
      .bus_req_o     (dcache_req),
      .bus_wdata_o   (dcache_wdata),
      .flushing_n_o  (dcache_flushing_n),
      .bus_valid_i   (dcache_rsp_valid)
   );

   ////////////////////////////////////////
   // Arbiter and slave
   ////////////////////////////////////////

   cache_arbiter i_cache_arbiter (
      .clk_i               (clk_i),
      .rst_i               (rst_i),
      .icache_blocking_n_i (icache_blocking_n),
      .icache_flushing_n_i (icache_flushing_n),
      .dcache_flushing_n_i (dcache_flushing_n),
      .icache_bus_addr_i   (icache_bus_addr),
      .icache_bus_valid_i  (icache_bus_valid),
      .icache_bus_valid_o  (icache_rsp_valid),
      .dcache_bus_req_i    (dcache_req),
      .dcache_bus_valid_o  (dcache_rsp_valid),
      .bus_req_o           (bus_req),
      .bus_valid_i         (bus_valid)
   );

   // Only the data side writes, so wdata skips the arbiter
   bus_line_memory #(
      .MEM_LATENCY (MEM_LATENCY),
      .MEM_LINES   (MEM_LINES)
   ) i_bus_line_memory (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .bus_req_i   (bus_req),
      .bus_wdata_i (dcache_wdata),
      .bus_valid_o (bus_valid),
      .bus_rdata_o (bus_rdata)
   );

endmodule

//--- tests/tb_cache_bus_top.sv
`timescale 1ns/1ps

module tb_cache_bus_top;

   import cache_bus_pkg::*;

   localparam int unsigned MEM_LATENCY  = 4;
   localparam int unsigned MEM_LINES    = 256;
   localparam int unsigned DCACHE_LINES = 4;
   localparam int unsigned IDX_W        = $clog2(DCACHE_LINES);
   localparam int unsigned RAND_OPS     = 400;
   // Directed part is covered by the margin
   localparam int unsigned CYCLE_LIMIT  =
      RAND_OPS * (MEM_LATENCY + 4) * (DCACHE_LINES + 2) + 2000;
   // Clean flush only scans, one entry per cycle, then done
   localparam int          CLEAN_FLUSH_CYCLES = DCACHE_LINES + 2;

   logic             clk;
   logic             rst;
   logic             miss_valid;
   line_addr_t       miss_addr;
   logic             fill_done;
   line_data_t       fill_line;
   logic             store_valid;
   logic [IDX_W-1:0] store_index;
   line_addr_t       store_addr;
   line_data_t       store_data;
   logic             flush_start;
   logic             flush_done;

   // Memory contents as seen after completed flushes
   line_data_t mem_model [line_addr_t];
   // Shadow of the data unit entries
   line_addr_t dc_addr  [DCACHE_LINES];
   line_data_t dc_data  [DCACHE_LINES];
   logic       dc_dirty [DCACHE_LINES];

   int         errors;
   int         cycles;
   int         fill_pending;
   int         flush_pending;
   int         done_events;
   int         fill_stamp;
   int         flush_stamp;
   int         flush_cycle;
   int         fill_checks;
   line_data_t fill_got;

   cache_bus_top #(
      .MEM_LATENCY  (MEM_LATENCY),
      .MEM_LINES    (MEM_LINES),
      .DCACHE_LINES (DCACHE_LINES)
   ) i_dut (
      .clk_i         (clk),
      .rst_i         (rst),
      .miss_valid_i  (miss_valid),
      .miss_addr_i   (miss_addr),
      .fill_done_o   (fill_done),
      .fill_line_o   (fill_line),
      .store_valid_i (store_valid),
      .store_index_i (store_index),
      .store_addr_i  (store_addr),
      .store_data_i  (store_data),
      .flush_start_i (flush_start),
      .flush_done_o  (flush_done)
   );

   ////////////////////////////////////////
   // Clock and run limit
   ////////////////////////////////////////

   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: a done pulse never came within %0d cycles", CYCLE_LIMIT);
         $display("Test failures found");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic report_error(input string msg);
      $display("[ERROR] %0t: %s", $time, msg);
      errors++;
   endtask

   function automatic line_data_t model_read(input line_addr_t addr);
      // Untouched lines read as zero
      if (mem_model.exists(addr)) begin
         return mem_model[addr];
      end
      return '0;
   endfunction

   function automatic line_data_t random_line();
      return {$urandom(), $urandom(), $urandom(), $urandom()};
   endfunction

   // True when the next flush has something to write back
   function automatic logic any_dirty();
      logic found;
      found = 1'b0;
      for (int i = 0; i < DCACHE_LINES; i++) begin
         found = found | dc_dirty[i];
      end
      return found;
   endfunction

   // Entries written back in index order, later one wins on same address
   task automatic commit_flush();
      for (int i = 0; i < DCACHE_LINES; i++) begin
         if (dc_dirty[i]) begin
            mem_model[dc_addr[i]] = dc_data[i];
            dc_dirty[i] = 1'b0;
         end
      end
   endtask

   // One cycle, done pulses sampled mid cycle
   task automatic cycle();
      @(negedge clk);
      if (fill_done) begin
         if (fill_pending == 0) begin
            report_error("fill_done pulsed with no miss outstanding");
         end else begin
            fill_pending--;
            done_events++;
            fill_stamp = done_events;
            fill_got   = fill_line;
         end
      end
      if (flush_done) begin
         if (flush_pending == 0) begin
            report_error("flush_done pulsed with no flush outstanding");
         end else begin
            flush_pending--;
            done_events++;
            flush_stamp = done_events;
            flush_cycle = cycles;
         end
      end
   endtask

   // Extra cycle lets the flush FSM leave its done state
   task automatic wait_idle();
      while (fill_pending != 0 || flush_pending != 0) begin
         cycle();
      end
      cycle();
   endtask

   task automatic store_line(input int idx, input line_addr_t addr, input line_data_t data);
      store_valid = 1'b1;
      store_index = IDX_W'(idx);
      store_addr  = addr;
      store_data  = data;
      dc_addr[idx]  = addr;
      dc_data[idx]  = data;
      dc_dirty[idx] = 1'b1;
      cycle();
      store_valid = 1'b0;
   endtask

   task automatic check_fill(input line_addr_t addr, input line_data_t expected);
      fill_checks++;
      if (fill_got !== expected) begin
         report_error($sformatf("fill of line %0h returned %h, expected %h",
                                addr, fill_got, expected));
      end
   endtask

   // Miss alone, checked against the model
   task automatic fill_line_op(input line_addr_t addr);
      miss_valid = 1'b1;
      miss_addr  = addr;
      fill_pending++;
      cycle();
      miss_valid = 1'b0;
      wait_idle();
      check_fill(addr, model_read(addr));
   endtask

   // A flush with nothing dirty must not touch the bus
   task automatic flush_op();
      logic clean;
      int   start;
      clean = ~any_dirty();
      start = cycles;
      flush_start = 1'b1;
      flush_pending++;
      cycle();
      flush_start = 1'b0;
      wait_idle();
      if (clean && (flush_cycle - start > CLEAN_FLUSH_CYCLES)) begin
         report_error($sformatf("flush with no dirty line took %0d cycles",
                                flush_cycle - start));
      end
      commit_flush();
   endtask

   // Blocked icache keeps the bus, so the fill sees memory before the flush
   task automatic miss_and_flush_op(input line_addr_t addr);
      line_data_t expected;
      logic       ordered;
      expected    = model_read(addr);
      // An empty flush never waits for the bus and may end first
      ordered     = any_dirty();
      miss_valid  = 1'b1;
      miss_addr   = addr;
      flush_start = 1'b1;
      fill_pending++;
      flush_pending++;
      cycle();
      miss_valid  = 1'b0;
      flush_start = 1'b0;
      wait_idle();
      if (ordered && fill_stamp > flush_stamp) begin
         report_error("flush_done arrived before fill_done on a shared start");
      end
      check_fill(addr, expected);
      commit_flush();
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial begin
      int         op;
      line_addr_t addr;
      line_data_t data_a;
      line_data_t data_b;

      void'($urandom(32'h4416e484));
      rst         = 1'b1;
      miss_valid  = 1'b0;
      miss_addr   = '0;
      store_valid = 1'b0;
      store_index = '0;
      store_addr  = '0;
      store_data  = '0;
      flush_start = 1'b0;
      errors = 0;
      cycles = 0;
      fill_pending  = 0;
      flush_pending = 0;
      done_events   = 0;
      fill_stamp    = 0;
      flush_stamp   = 0;
      flush_cycle   = 0;
      fill_checks   = 0;
      for (int i = 0; i < DCACHE_LINES; i++) begin
         dc_dirty[i] = 1'b0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Quiet after reset, any done pulse is flagged
      repeat (10) cycle();

      // Never written line, then an empty flush
      fill_line_op(16'h0005);
      flush_op();
      fill_line_op(16'h0005);
      fill_line_op(16'h0009);

      // Write back two lines and read them over the bus
      data_a = random_line();
      data_b = random_line();
      store_line(0, 16'h0005, data_a);
      store_line(1, 16'h0009, data_b);
      flush_op();
      // Back to back flush, nothing left dirty
      flush_op();
      fill_line_op(16'h0005);
      fill_line_op(16'h0009);

      // Same cycle miss and flush on a dirty address
      store_line(2, 16'h0005, random_line());
      miss_and_flush_op(16'h0005);
      fill_line_op(16'h0005);

      ////////////////////////////////////////
      // Random mix
      ////////////////////////////////////////

      for (int n = 0; n < RAND_OPS; n++) begin
         op   = $urandom_range(0, 9);
         // Small range so addresses collide often
         addr = line_addr_t'($urandom_range(0, 31));
         if (op <= 3) begin
            store_line($urandom_range(0, DCACHE_LINES - 1), addr, random_line());
         end else if (op <= 5) begin
            flush_op();
         end else if (op <= 8) begin
            fill_line_op(addr);
         end else begin
            miss_and_flush_op(addr);
         end
      end

      repeat (5) cycle();
      $display("Errors: %0d, fill checks: %0d, done pulses: %0d, cycles: %0d",
               errors, fill_checks, done_events, cycles);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- src.f
hdl/cache_bus_pkg.sv
hdl/icache_fill_unit.sv
hdl/dcache_line_unit.sv
hdl/cache_arbiter.sv
hdl/bus_line_memory.sv
hdl/cache_bus_top.sv
tests/tb_cache_bus_top.sv
